/* hdl/client_select.sv */
`default_nettype none

// sharing policy for the buffer bank
// accelerator datapath vs LiDAR pipeline
module client_select (
  // 1 = accelerator, 0 = LiDAR
  input  wire logic                     choose_mux_in,

  // input buffer requests of both clients
  input  wire ram_share_pkg::ibuf_req_t accel_ibuf,
  input  wire ram_share_pkg::ibuf_req_t lidar_ibuf,

  // output buffer requests of both clients
  input  wire ram_share_pkg::obuf_req_t accel_obuf,
  input  wire ram_share_pkg::obuf_req_t lidar_obuf,

  // requests of the selected client
  output ram_share_pkg::ibuf_req_t      ibuf_req,
  output ram_share_pkg::obuf_req_t      obuf_req
);

  // purely combinational, switch applies in the same cycle
  // whole struct is muxed so strobes, addresses and data
  // always come from the same client
  // unselected client is dropped entirely, no queuing
  // one select drives both buffers

  // input buffer path
  // write strobe, address, data and read side together
  always_comb begin
    if (choose_mux_in) begin
      ibuf_req = accel_ibuf;
    end else begin
      ibuf_req = lidar_ibuf;
    end
  end

  // output buffer path
  // covers memory port and pu port in one go
  always_comb begin
    if (choose_mux_in) begin
      obuf_req = accel_obuf;
    end else begin
      obuf_req = lidar_obuf;
    end
  end

  // read data needs no mux here
  // each buffer has a single read port per side,
  // its registered output goes to whoever is selected

endmodule

`default_nettype wire

/* hdl/ibuf_ram.sv */
`default_nettype none

// input buffer
// written one memory word at a time, read one wide row at a time
module ibuf_ram (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // selected client request
  input  wire ram_share_pkg::ibuf_req_t req,

  // registered wide row, lane 0 in the low bits
  output ram_share_pkg::ibuf_word_t     read_data
);

  // write address split into row and half
  ram_share_pkg::ibuf_row_t  wr_row;
  ram_share_pkg::ibuf_lane_t wr_lane;

  // lane words of the row being read
  logic [ram_share_pkg::IBUF_RATIO-1:0][ram_share_pkg::MEM_DATA_W-1:0] rd_row;

  // high bits pick the row, low bit the half
  assign {wr_row, wr_lane} = req.write_addr;

  // one storage array per lane
  for (genvar l = 0; l < ram_share_pkg::IBUF_RATIO; l++) begin : g_lane
    // no reset on storage
    ram_share_pkg::mem_word_t mem [ram_share_pkg::IBUF_ROWS];

    // only the addressed half of the row takes the word
    always_ff @(posedge clk) begin
      if (req.write_req && (wr_lane == ram_share_pkg::ibuf_lane_t'(l))) begin
        mem[wr_row] <= req.write_data;
      end
    end

    // all lanes look at the same row on a read
    assign rd_row[l] = mem[req.read_addr];
  end

  // read register
  // old contents on a same-cycle write, since storage updates at the edge
  // holds until the next read strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_data <= '0;
    end else if (req.read_req) begin
      // packed lanes flatten with lane 0 at the bottom
      read_data <= rd_row;
    end
  end

endmodule

`default_nettype wire

/* hdl/obuf_ram.sv */
`default_nettype none

// output buffer
// narrow memory-side port addressed by lane,
// wide processing-unit port addressed by row
module obuf_ram (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // selected client request, both ports
  input  wire ram_share_pkg::obuf_req_t req,

  // registered read data of each port
  output ram_share_pkg::mem_word_t      mem_read_data,
  output ram_share_pkg::pu_word_t       pu_read_data
);

  // memory-side write address fields
  ram_share_pkg::obuf_row_t  mem_wr_row;
  ram_share_pkg::obuf_lane_t mem_wr_lane;

  // memory-side read address fields
  ram_share_pkg::obuf_row_t  mem_rd_row;
  ram_share_pkg::obuf_lane_t mem_rd_lane;

  // every lane of the memory-side read row
  logic [ram_share_pkg::OBUF_RATIO-1:0][ram_share_pkg::MEM_DATA_W-1:0] mem_rd_row_data;

  // every lane of the pu read row
  logic [ram_share_pkg::OBUF_RATIO-1:0][ram_share_pkg::MEM_DATA_W-1:0] pu_rd_row_data;

  // {row, lane} split of the memory addresses
  assign {mem_wr_row, mem_wr_lane} = req.mem_write_addr;
  assign {mem_rd_row, mem_rd_lane} = req.mem_read_addr;

  // one storage array per lane
  for (genvar l = 0; l < ram_share_pkg::OBUF_RATIO; l++) begin : g_lane
    // storage, not reset
    ram_share_pkg::mem_word_t mem [ram_share_pkg::OBUF_ROWS];

    // this lane's slice of the pu word
    ram_share_pkg::mem_word_t pu_lane_data;

    // lane 0 from the low bits
    assign pu_lane_data =
      req.pu_write_data[l*ram_share_pkg::MEM_DATA_W +: ram_share_pkg::MEM_DATA_W];

    // pu write goes first, then the memory-side write
    // same row and lane -> memory word is the last update and wins
    always_ff @(posedge clk) begin
      if (req.pu_write_req) begin
        mem[req.pu_write_addr] <= pu_lane_data;
      end
      if (req.mem_write_req && (mem_wr_lane == ram_share_pkg::obuf_lane_t'(l))) begin
        mem[mem_wr_row] <= req.mem_write_data;
      end
    end

    // two independent read taps per lane
    assign mem_rd_row_data[l] = mem[mem_rd_row];
    assign pu_rd_row_data[l]  = mem[req.pu_read_addr];
  end

  // memory-side read register
  // one lane out of the addressed row
  // read before write, storage only changes at the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_read_data <= '0;
    end else if (req.mem_read_req) begin
      mem_read_data <= mem_rd_row_data[mem_rd_lane];
    end
  end

  // pu-side read register
  // whole row, lane 0 in the low bits
  // independent of the memory-side read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pu_read_data <= '0;
    end else if (req.pu_read_req) begin
      pu_read_data <= pu_rd_row_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/ram_mux.sv */
`default_nettype none

// shared buffer bank of the accelerator
// accelerator datapath and LiDAR pipeline take turns on
// the input buffer and the output buffer
module ram_mux (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // level select, 1 = accelerator, 0 = LiDAR
  input  wire logic                     choose_mux_in,

  // input buffer requests
  input  wire ram_share_pkg::ibuf_req_t accel_ibuf,
  input  wire ram_share_pkg::ibuf_req_t lidar_ibuf,

  // output buffer requests
  input  wire ram_share_pkg::obuf_req_t accel_obuf,
  input  wire ram_share_pkg::obuf_req_t lidar_obuf,

  // read data, shared by both clients
  output ram_share_pkg::ibuf_word_t     ibuf_read_data,
  output ram_share_pkg::mem_word_t      obuf_mem_read_data,
  output ram_share_pkg::pu_word_t       obuf_pu_read_data
);

  // requests of the selected client
  ram_share_pkg::ibuf_req_t ibuf_req;
  ram_share_pkg::obuf_req_t obuf_req;

  // client select, zero cycles
  client_select client_select_i (
    .choose_mux_in (choose_mux_in),
    .accel_ibuf    (accel_ibuf),
    .lidar_ibuf    (lidar_ibuf),
    .accel_obuf    (accel_obuf),
    .lidar_obuf    (lidar_obuf),
    .ibuf_req      (ibuf_req),
    .obuf_req      (obuf_req)
  );

  // input buffer
  // memory-word writes, wide-word reads
  ibuf_ram ibuf_ram_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (ibuf_req),
    .read_data (ibuf_read_data)
  );

  // output buffer
  // lane port to memory, row port to processing unit
  obuf_ram obuf_ram_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (obuf_req),
    .mem_read_data (obuf_mem_read_data),
    .pu_read_data  (obuf_pu_read_data)
  );

endmodule

`default_nettype wire

/* hdl/ram_share_pkg.sv */
`default_nettype none

package ram_share_pkg;

  // one memory-side word, stands in for the 256-bit bus
  localparam int MEM_DATA_W = 32;

  // memory words per wide word
  localparam int IBUF_RATIO = 2;
  localparam int OBUF_RATIO = 4;

  // wide-word rows per buffer
  localparam int IBUF_ROWS = 32;
  localparam int OBUF_ROWS = 32;

  // derived address field widths
  localparam int IBUF_ROW_W  = $clog2(IBUF_ROWS);
  localparam int IBUF_LANE_W = $clog2(IBUF_RATIO);
  localparam int OBUF_ROW_W  = $clog2(OBUF_ROWS);
  localparam int OBUF_LANE_W = $clog2(OBUF_RATIO);

  // data words
  typedef logic [MEM_DATA_W-1:0]            mem_word_t;
  typedef logic [IBUF_RATIO*MEM_DATA_W-1:0] ibuf_word_t;
  typedef logic [OBUF_RATIO*MEM_DATA_W-1:0] pu_word_t;

  // input buffer addresses, memory address is {row, half}
  typedef logic [IBUF_ROW_W-1:0]             ibuf_row_t;
  typedef logic [IBUF_LANE_W-1:0]            ibuf_lane_t;
  typedef logic [IBUF_ROW_W+IBUF_LANE_W-1:0] ibuf_mem_addr_t;

  // output buffer addresses, memory address is {row, lane}
  typedef logic [OBUF_ROW_W-1:0]             obuf_row_t;
  typedef logic [OBUF_LANE_W-1:0]            obuf_lane_t;
  typedef logic [OBUF_ROW_W+OBUF_LANE_W-1:0] obuf_mem_addr_t;

  // one client's input buffer request
  typedef struct packed {
    logic           write_req;
    ibuf_mem_addr_t write_addr;
    mem_word_t      write_data;
    logic           read_req;
    ibuf_row_t      read_addr;
  } ibuf_req_t;

  // one client's output buffer request, memory port then pu port
  typedef struct packed {
    logic           mem_write_req;
    obuf_mem_addr_t mem_write_addr;
    mem_word_t      mem_write_data;
    logic           mem_read_req;
    obuf_mem_addr_t mem_read_addr;
    logic           pu_write_req;
    obuf_row_t      pu_write_addr;
    pu_word_t       pu_write_data;
    logic           pu_read_req;
    obuf_row_t      pu_read_addr;
  } obuf_req_t;

endpackage

`default_nettype wire

/* ram_mux.f */
hdl/ram_share_pkg.sv
hdl/client_select.sv
hdl/ibuf_ram.sv
hdl/obuf_ram.sv
hdl/ram_mux.sv
testbench/ram_mux_properties.sv
testbench/ram_mux_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the ram_mux testbench with Verilator and runs it
# exit status is the simulator's, nonzero on $fatal or a failed assertion

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ram_mux_tb \
  -Mdir obj_dir \
  -f ram_mux.f \
  && ./obj_dir/Vram_mux_tb \
  || { echo "ram_mux simulation did not complete cleanly"; exit 1; }

/* testbench/ram_mux_properties.sv */
`default_nettype none

// concurrent checks on the shared buffer bank
// looks at the selected requests inside ram_mux
module ram_mux_properties (
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire ram_share_pkg::ibuf_req_t ibuf_req,
  input wire ram_share_pkg::obuf_req_t obuf_req,
  input wire ram_share_pkg::ibuf_word_t ibuf_read_data,
  input wire ram_share_pkg::mem_word_t obuf_mem_read_data,
  input wire ram_share_pkg::pu_word_t  obuf_pu_read_data
);
  timeunit 1ns;
  timeprecision 1ps;

  // read registers come out of reset cleared
  reset_clear_a : assert property (@(posedge clk)
    $rose(rst_n) |-> (ibuf_read_data == '0) && (obuf_mem_read_data == '0) &&
                     (obuf_pu_read_data == '0))
    else $error("read data not zero in the first cycle after reset release");

  // no selected ibuf read, output holds
  ibuf_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    !ibuf_req.read_req |=> $stable(ibuf_read_data))
    else $error("ibuf read data changed without a read strobe");

  // memory-side read port holds on its own strobe
  obuf_mem_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    !obuf_req.mem_read_req |=> $stable(obuf_mem_read_data))
    else $error("obuf memory read data changed without a read strobe");

  // pu read port, independent strobe
  obuf_pu_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    !obuf_req.pu_read_req |=> $stable(obuf_pu_read_data))
    else $error("obuf pu read data changed without a read strobe");

endmodule

bind ram_mux ram_mux_properties ram_mux_properties_i (
  .clk                (clk),
  .rst_n              (rst_n),
  .ibuf_req           (ibuf_req),
  .obuf_req           (obuf_req),
  .ibuf_read_data     (ibuf_read_data),
  .obuf_mem_read_data (obuf_mem_read_data),
  .obuf_pu_read_data  (obuf_pu_read_data)
);

`default_nettype wire

/* testbench/ram_mux_tb.sv */
`default_nettype none

// testbench for the shared buffer bank
// random requests on both clients checked against an array model
module ram_mux_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // phase lengths in cycles
  localparam int RESET_CYCLES  = 4;
  localparam int IBUF_WORDS    = ram_share_pkg::IBUF_RATIO * ram_share_pkg::IBUF_ROWS;
  localparam int OBUF_WORDS    = ram_share_pkg::OBUF_RATIO * ram_share_pkg::OBUF_ROWS;
  localparam int ROWS          = ram_share_pkg::OBUF_ROWS;
  localparam int RANDOM_CYCLES = 400;
  localparam int FLUSH_CYCLES  = 2;
  localparam int TEST_CYCLES   = RESET_CYCLES + 1 + IBUF_WORDS + ROWS + OBUF_WORDS + ROWS +
                                 RANDOM_CYCLES + FLUSH_CYCLES;
  // about three times the expected run length
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

  logic clk = 1'b0;
  logic rst_n;
  logic choose_mux_in;
  ram_share_pkg::ibuf_req_t accel_ibuf;
  ram_share_pkg::ibuf_req_t lidar_ibuf;
  ram_share_pkg::obuf_req_t accel_obuf;
  ram_share_pkg::obuf_req_t lidar_obuf;
  ram_share_pkg::ibuf_word_t ibuf_read_data;
  ram_share_pkg::mem_word_t  obuf_mem_read_data;
  ram_share_pkg::pu_word_t   obuf_pu_read_data;

  // model of both buffers indexed [lane][row]
  ram_share_pkg::mem_word_t ibuf_model [ram_share_pkg::IBUF_RATIO][ram_share_pkg::IBUF_ROWS];
  ram_share_pkg::mem_word_t obuf_model [ram_share_pkg::OBUF_RATIO][ram_share_pkg::OBUF_ROWS];

  // expected outputs trail the read strobes by one cycle
  ram_share_pkg::ibuf_word_t exp_ibuf = '0;
  ram_share_pkg::mem_word_t  exp_mem  = '0;
  ram_share_pkg::pu_word_t   exp_pu   = '0;

  logic [31:0] lfsr_state = 32'd74;
  int          cycle_count = 0;

  ram_mux ram_mux_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .choose_mux_in      (choose_mux_in),
    .accel_ibuf         (accel_ibuf),
    .lidar_ibuf         (lidar_ibuf),
    .accel_obuf         (accel_obuf),
    .lidar_obuf         (lidar_obuf),
    .ibuf_read_data     (ibuf_read_data),
    .obuf_mem_read_data (obuf_mem_read_data),
    .obuf_pu_read_data  (obuf_pu_read_data)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("test failed");
      $fatal(1, "timed out after %0d cycles before all phases completed", cycle_count);
    end
  end

  // galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one LFSR step per bit with the result in the low n bits
  function automatic logic [127:0] take_bits(input int n);
    logic [127:0] val;
    int           i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val = (val << 1) | 128'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  // random ibuf request that sometimes reads the row it writes
  function automatic ram_share_pkg::ibuf_req_t random_ibuf_req();
    ram_share_pkg::ibuf_req_t r;
    r.write_req  = 1'(take_bits(1));
    r.write_addr = ram_share_pkg::ibuf_mem_addr_t'(take_bits(ram_share_pkg::IBUF_ROW_W + 1));
    r.write_data = ram_share_pkg::mem_word_t'(take_bits(ram_share_pkg::MEM_DATA_W));
    r.read_req   = 1'(take_bits(1));
    r.read_addr  = ram_share_pkg::ibuf_row_t'(take_bits(ram_share_pkg::IBUF_ROW_W));
    // read before write on the same row
    if (2'(take_bits(2)) == 2'd0) begin
      r.read_addr = r.write_addr[ram_share_pkg::IBUF_LANE_W +: ram_share_pkg::IBUF_ROW_W];
    end
    return r;
  endfunction

  // random obuf request with collisions mixed in
  function automatic ram_share_pkg::obuf_req_t random_obuf_req();
    ram_share_pkg::obuf_req_t  r;
    ram_share_pkg::obuf_lane_t lane;
    r.mem_write_req  = 1'(take_bits(1));
    r.mem_write_addr = ram_share_pkg::obuf_mem_addr_t'(take_bits(ram_share_pkg::OBUF_ROW_W + 2));
    r.mem_write_data = ram_share_pkg::mem_word_t'(take_bits(ram_share_pkg::MEM_DATA_W));
    r.mem_read_req   = 1'(take_bits(1));
    r.mem_read_addr  = ram_share_pkg::obuf_mem_addr_t'(take_bits(ram_share_pkg::OBUF_ROW_W + 2));
    r.pu_write_req   = 1'(take_bits(1));
    r.pu_write_addr  = ram_share_pkg::obuf_row_t'(take_bits(ram_share_pkg::OBUF_ROW_W));
    r.pu_write_data  = ram_share_pkg::pu_word_t'(take_bits(4 * ram_share_pkg::MEM_DATA_W));
    r.pu_read_req    = 1'(take_bits(1));
    r.pu_read_addr   = ram_share_pkg::obuf_row_t'(take_bits(ram_share_pkg::OBUF_ROW_W));
    lane = r.mem_write_addr[ram_share_pkg::OBUF_LANE_W-1:0];
    // memory and pu write on the same row
    if (2'(take_bits(2)) == 2'd0) begin
      r.mem_write_addr = {r.pu_write_addr, lane};
    end
    // reads of the locations written this cycle
    if (2'(take_bits(2)) == 2'd0) begin
      r.mem_read_addr = r.mem_write_addr;
    end
    if (2'(take_bits(2)) == 2'd0) begin
      r.pu_read_addr = r.pu_write_addr;
    end
    return r;
  endfunction

  // single comparison point
  task automatic compare(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected);
      $display("test failed");
      $fatal(1, "%s does not match the model", name);
    end
  endtask

  task automatic check_outputs();
    compare("ibuf_read_data", 128'(ibuf_read_data), 128'(exp_ibuf));
    compare("obuf_mem_read_data", 128'(obuf_mem_read_data), 128'(exp_mem));
    compare("obuf_pu_read_data", 128'(obuf_pu_read_data), 128'(exp_pu));
  endtask

  // selected client only with reads before writes
  task automatic apply_model(input logic sel,
                             input ram_share_pkg::ibuf_req_t ia,
                             input ram_share_pkg::ibuf_req_t il,
                             input ram_share_pkg::obuf_req_t oa,
                             input ram_share_pkg::obuf_req_t ol);
    ram_share_pkg::ibuf_req_t  ir;
    ram_share_pkg::obuf_req_t  orq;
    ram_share_pkg::ibuf_row_t  i_row;
    ram_share_pkg::ibuf_lane_t i_lane;
    ram_share_pkg::obuf_row_t  o_row;
    ram_share_pkg::obuf_lane_t o_lane;
    int                        l;
    ir  = sel ? ia : il;
    orq = sel ? oa : ol;
    // wide ibuf row with lane 0 lowest
    if (ir.read_req) begin
      exp_ibuf = '0;
      for (l = ram_share_pkg::IBUF_RATIO - 1; l >= 0; l--) begin
        exp_ibuf = (exp_ibuf << ram_share_pkg::MEM_DATA_W) |
                   ram_share_pkg::ibuf_word_t'(ibuf_model[l][ir.read_addr]);
      end
    end
    if (orq.mem_read_req) begin
      {o_row, o_lane} = orq.mem_read_addr;
      exp_mem = obuf_model[o_lane][o_row];
    end
    if (orq.pu_read_req) begin
      exp_pu = '0;
      for (l = ram_share_pkg::OBUF_RATIO - 1; l >= 0; l--) begin
        exp_pu = (exp_pu << ram_share_pkg::MEM_DATA_W) |
                 ram_share_pkg::pu_word_t'(obuf_model[l][orq.pu_read_addr]);
      end
    end
    if (ir.write_req) begin
      {i_row, i_lane} = ir.write_addr;
      ibuf_model[i_lane][i_row] = ir.write_data;
    end
    // pu word first with the memory lane on top
    if (orq.pu_write_req) begin
      for (l = 0; l < ram_share_pkg::OBUF_RATIO; l++) begin
        obuf_model[l][orq.pu_write_addr] =
          orq.pu_write_data[l*ram_share_pkg::MEM_DATA_W +: ram_share_pkg::MEM_DATA_W];
      end
    end
    if (orq.mem_write_req) begin
      {o_row, o_lane} = orq.mem_write_addr;
      obuf_model[o_lane][o_row] = orq.mem_write_data;
    end
  endtask

  // drive at the edge and check at the falling edge before advancing the model
  task automatic run_cycle(input logic sel,
                           input ram_share_pkg::ibuf_req_t ia,
                           input ram_share_pkg::ibuf_req_t il,
                           input ram_share_pkg::obuf_req_t oa,
                           input ram_share_pkg::obuf_req_t ol);
    @(posedge clk);
    choose_mux_in <= sel;
    accel_ibuf    <= ia;
    lidar_ibuf    <= il;
    accel_obuf    <= oa;
    lidar_obuf    <= ol;
    @(negedge clk);
    check_outputs();
    apply_model(sel, ia, il, oa, ol);
  endtask

  // directed request on a random client with noise on the other one
  task automatic drive_selected(input ram_share_pkg::ibuf_req_t ir,
                                input ram_share_pkg::obuf_req_t orq);
    logic                     sel;
    ram_share_pkg::ibuf_req_t noise_i;
    ram_share_pkg::obuf_req_t noise_o;
    sel     = 1'(take_bits(1));
    noise_i = random_ibuf_req();
    noise_o = random_obuf_req();
    if (sel) begin
      run_cycle(1'b1, ir, noise_i, orq, noise_o);
    end else begin
      run_cycle(1'b0, noise_i, ir, noise_o, orq);
    end
  endtask

  initial begin
    ram_share_pkg::ibuf_req_t ir;
    ram_share_pkg::obuf_req_t orq;
    int                       i;
    rst_n         <= 1'b0;
    choose_mux_in <= 1'b0;
    accel_ibuf    <= '0;
    lidar_ibuf    <= '0;
    accel_obuf    <= '0;
    lidar_obuf    <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // cleared read registers
    @(negedge clk);
    check_outputs();

    // fill every ibuf half by memory-word writes
    for (i = 0; i < IBUF_WORDS; i++) begin
      ir            = '0;
      ir.write_req  = 1'b1;
      ir.write_addr = ram_share_pkg::ibuf_mem_addr_t'(i);
      ir.write_data = ram_share_pkg::mem_word_t'(take_bits(ram_share_pkg::MEM_DATA_W));
      drive_selected(ir, '0);
    end

    // read ibuf rows back while filling obuf rows through the pu port
    for (i = 0; i < ROWS; i++) begin
      ir                = '0;
      ir.read_req       = 1'b1;
      ir.read_addr      = ram_share_pkg::ibuf_row_t'(i);
      orq               = '0;
      orq.pu_write_req  = 1'b1;
      orq.pu_write_addr = ram_share_pkg::obuf_row_t'(i);
      orq.pu_write_data = ram_share_pkg::pu_word_t'(take_bits(4 * ram_share_pkg::MEM_DATA_W));
      drive_selected(ir, orq);
    end

    // lane by lane through the memory port overwriting each word as it is read
    for (i = 0; i < OBUF_WORDS; i++) begin
      orq                = '0;
      orq.mem_read_req   = 1'b1;
      orq.mem_read_addr  = ram_share_pkg::obuf_mem_addr_t'(i);
      orq.mem_write_req  = 1'b1;
      orq.mem_write_addr = ram_share_pkg::obuf_mem_addr_t'(i);
      orq.mem_write_data = ram_share_pkg::mem_word_t'(take_bits(ram_share_pkg::MEM_DATA_W));
      drive_selected('0, orq);
    end

    // rows built from memory words read back whole
    for (i = 0; i < ROWS; i++) begin
      orq              = '0;
      orq.pu_read_req  = 1'b1;
      orq.pu_read_addr = ram_share_pkg::obuf_row_t'(i);
      drive_selected('0, orq);
    end

    // both clients random with the select toggling
    for (i = 0; i < RANDOM_CYCLES; i++) begin
      run_cycle(1'(take_bits(1)), random_ibuf_req(), random_ibuf_req(),
                random_obuf_req(), random_obuf_req());
    end

    // idle cycles for the last reads and held values
    for (i = 0; i < FLUSH_CYCLES; i++) begin
      run_cycle(1'(take_bits(1)), '0, '0, '0, '0);
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
